/* sdp_wdma_dat_out.f */
hdl/sdp_wdma_pkg.sv
hdl/sdp_wdma_cmd_hold.sv
hdl/sdp_wdma_lane_mux.sv
hdl/sdp_wdma_beat_seq.sv
hdl/sdp_wdma_eq_status.sv
hdl/sdp_wdma_dat_out.sv
tb/tb_sdp_wdma_dat_out.sv

/* run_sim.sh */
#!/bin/sh
# build the write-DMA data-out testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal \
    -f sdp_wdma_dat_out.f \
    --top-module tb_sdp_wdma_dat_out \
    -Mdir obj_dir -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  echo "result: pass"
  exit 0
fi

echo "result: fail, see sim.log"
exit 1

/* tb/tb_sdp_wdma_dat_out.sv */
// directed testbench for the write-DMA data-out top with lane FIFO models, a request monitor and five tests
`timescale 1ns/10ps

module tb_sdp_wdma_dat_out;

  import sdp_wdma_pkg::*;

  localparam int TIMEOUT = 2000;

  logic                       autosa_core_clk;
  logic                       autosa_core_rstn;
  logic                       op_load;
  logic                       cmd2dat_dma_pvld;
  logic [ADDR_W+SIZE_W+1:0]   cmd2dat_dma_pd;
  logic                       cmd2dat_dma_prdy;
  logic                       dma_wr_req_vld;
  logic [REQ_W-1:0]           dma_wr_req_pd;
  logic                       dma_wr_req_rdy;
  logic [NUM_LANES-1:0]       dfifo_rd_pvld;
  logic [LANE_W-1:0]          dfifo_rd_pd [NUM_LANES];
  logic [NUM_LANES-1:0]       dfifo_rd_prdy;
  logic                       reg2dp_output_dst;
  logic [1:0]                 reg2dp_ew_alu_algo;
  logic                       reg2dp_ew_alu_bypass;
  logic                       reg2dp_ew_bypass;
  logic                       reg2dp_interrupt_ptr;
  logic                       dp2reg_done;
  logic                       dp2reg_status_unequal;
  logic                       intr_req_ptr;
  logic                       intr_req_pvld;

  // lane FIFO contents and the expected and seen requests
  logic [LANE_W-1:0]          lane_q [NUM_LANES][$];
  logic [REQ_W-1:0]           exp_q[$];
  logic [REQ_W-1:0]           got_q[$];
  logic [NUM_LANES-1:0]       lane_pop;
  // monitor state
  int cyc, errors, tests_run, failed_tests;
  int intr_cnt, intr_cyc, intr_at, done_cnt, done_cyc, bp_err, quiet_err;
  logic intr_ptr_seen;
  bit rand_rdy, bp_check, quiet_check;

  sdp_wdma_dat_out UUT (
    .autosa_core_clk(autosa_core_clk), .autosa_core_rstn(autosa_core_rstn),
    .op_load(op_load), .cmd2dat_dma_pvld(cmd2dat_dma_pvld),
    .cmd2dat_dma_pd(cmd2dat_dma_pd), .cmd2dat_dma_prdy(cmd2dat_dma_prdy),
    .dma_wr_req_vld(dma_wr_req_vld), .dma_wr_req_pd(dma_wr_req_pd),
    .dma_wr_req_rdy(dma_wr_req_rdy), .dfifo_rd_pvld(dfifo_rd_pvld),
    .dfifo_rd_pd(dfifo_rd_pd), .dfifo_rd_prdy(dfifo_rd_prdy),
    .reg2dp_output_dst(reg2dp_output_dst), .reg2dp_ew_alu_algo(reg2dp_ew_alu_algo),
    .reg2dp_ew_alu_bypass(reg2dp_ew_alu_bypass), .reg2dp_ew_bypass(reg2dp_ew_bypass),
    .reg2dp_interrupt_ptr(reg2dp_interrupt_ptr), .dp2reg_done(dp2reg_done),
    .dp2reg_status_unequal(dp2reg_status_unequal), .intr_req_ptr(intr_req_ptr),
    .intr_req_pvld(intr_req_pvld)
  );

  // ============================================================
  // clock, lane models, monitor
  // ============================================================

  initial begin
    autosa_core_clk = 1'b0;
    forever #10 autosa_core_clk = ~autosa_core_clk;
  end

  always @(posedge autosa_core_clk) cyc <= cyc + 1;

  // pop decided on stable values and applied after the edge
  always begin
    @(negedge autosa_core_clk);
    lane_pop = dfifo_rd_pvld & dfifo_rd_prdy;
    @(posedge autosa_core_clk);
    #2;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_pop[i]) begin
        void'(lane_q[i].pop_front());
      end
      dfifo_rd_pvld[i] = (lane_q[i].size() != 0);
      dfifo_rd_pd[i]   = (lane_q[i].size() != 0) ? lane_q[i][0] : '0;
    end
  end

  // random DMA ready while enabled
  always @(posedge autosa_core_clk) begin
    #2;
    if (rand_rdy) dma_wr_req_rdy = ($urandom_range(0, 1) != 0);
  end

  // request monitor sampling before the edge that takes the packet
  always @(negedge autosa_core_clk) begin
    if (autosa_core_rstn) begin
      if (dma_wr_req_vld && dma_wr_req_rdy) got_q.push_back(dma_wr_req_pd);
      if (intr_req_pvld) begin
        intr_cnt++;
        intr_cyc      = cyc;
        intr_at       = got_q.size();
        intr_ptr_seen = intr_req_ptr;
      end
      if (dp2reg_done) begin
        done_cnt++;
        done_cyc = cyc;
      end
      // no lane read while the DMA stalls
      if (bp_check && !dma_wr_req_rdy && (dfifo_rd_prdy != '0)) bp_err++;
      if (quiet_check && dma_wr_req_vld) quiet_err++;
    end
  end

  // ============================================================
  // helpers
  // ============================================================

  task automatic step();
    @(posedge autosa_core_clk);
    #2;
  endtask

  // after the monitor has run
  task automatic sample();
    @(negedge autosa_core_clk);
    #1;
  endtask

  task automatic check_val(input string name, input logic [REQ_W-1:0] got,
                           input logic [REQ_W-1:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    assert (ok) else begin
      $display("error at %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %s: clean", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errs_at_start);
      failed_tests++;
    end
  endtask

  task automatic send_cmd(input logic [ADDR_W-1:0] addr, input logic [SIZE_W-1:0] size,
                          input logic cube);
    bit accepted;
    accepted = 0;
    step();
    cmd2dat_dma_pvld = 1'b1;
    // cube end, odd bit, size, address
    cmd2dat_dma_pd   = {cube, 1'b0, size, addr};
    for (int t = 0; t < TIMEOUT && !accepted; t++) begin
      sample();
      accepted = cmd2dat_dma_prdy;
    end
    step();
    cmd2dat_dma_pvld = 1'b0;
    check_true(accepted, "command was never accepted");
  endtask

  // predict packets, load lanes, then send
  task automatic issue_cmd(input logic [ADDR_W-1:0] addr, input logic [SIZE_W-1:0] size,
                           input logic cube);
    logic [LANE_W-1:0] data;
    // byte address, size, require-ack on cube end
    exp_q.push_back({1'b0, 19'b0, cube, size, addr, 3'b000});
    for (int k = 0; k <= int'(size); k++) begin
      data = {$urandom, $urandom};
      lane_q[k % NUM_LANES].push_back(data);
      // data type and mask set
      exp_q.push_back({2'b11, data});
    end
    send_cmd(addr, size, cube);
  endtask

  task automatic wait_pkts(input int n);
    int t;
    t = 0;
    while (got_q.size() < n && t < TIMEOUT) begin
      sample();
      t++;
    end
    check_true(got_q.size() >= n, "timeout waiting for DMA write requests");
  endtask

  task automatic wait_drain();
    int  t;
    bit  empty;
    t     = 0;
    empty = 0;
    while (!empty && t < TIMEOUT) begin
      sample();
      empty = cmd2dat_dma_prdy;
      for (int i = 0; i < NUM_LANES; i++) empty = empty && (lane_q[i].size() == 0);
      t++;
    end
    check_true(empty, "timeout waiting for lane FIFOs to drain");
  endtask

  task automatic compare_pkts();
    check_true(got_q.size() == exp_q.size(), "wrong number of DMA write requests");
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_val("dma_wr_req_pd", got_q[i], exp_q[i]);
    end
    got_q.delete();
    exp_q.delete();
  endtask

  // ============================================================
  // tests
  // ============================================================

  task automatic test_reset();
    int e0;
    e0 = errors;
    sample();
    check_val("dma_wr_req_vld", dma_wr_req_vld, 0);
    check_val("dfifo_rd_prdy", dfifo_rd_prdy, 0);
    check_val("dp2reg_done", dp2reg_done, 0);
    check_val("intr_req_pvld", intr_req_pvld, 0);
    check_val("dp2reg_status_unequal", dp2reg_status_unequal, 0);
    check_val("cmd2dat_dma_prdy", cmd2dat_dma_prdy, 1);
    report_test("reset", e0);
  endtask

  // six beats over lanes 0,1,2,3,0,1
  task automatic test_single();
    int e0;
    e0 = errors;
    issue_cmd(29'h0123_4567, 13'd5, 1'b0);
    wait_pkts(7);
    compare_pkts();
    report_test("single_cmd", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = errors;
    bp_err = 0;
    sample();
    rand_rdy = 1;
    bp_check = 1;
    issue_cmd(29'h0000_0abc, 13'd6, 1'b0);
    issue_cmd(29'h0001_0000, 13'd2, 1'b0);
    wait_pkts(12);
    sample();
    rand_rdy = 0;
    bp_check = 0;
    step();
    dma_wr_req_rdy = 1'b1;
    compare_pkts();
    check_true(bp_err == 0, "lane ready raised while DMA ready was low");
    report_test("backpressure", e0);
  endtask

  task automatic test_cube_end();
    int e0;
    int t;
    e0 = errors;
    t  = 0;
    step();
    reg2dp_interrupt_ptr = 1'b1;
    intr_cnt = 0;
    done_cnt = 0;
    issue_cmd(29'h1abc_def, 13'd3, 1'b1);
    wait_pkts(5);
    while (done_cnt == 0 && t < TIMEOUT) begin
      sample();
      t++;
    end
    // a second done pulse would show here
    repeat (3) sample();
    check_true(intr_cnt == 1, "interrupt request not seen exactly once");
    check_true(intr_at == 5, "interrupt request not with the last data packet");
    check_val("intr_req_ptr", intr_ptr_seen, 1);
    check_true(done_cnt == 1, "layer done did not pulse exactly once");
    check_true(done_cyc == intr_cyc + 1, "layer done not one cycle after the last beat");
    compare_pkts();
    report_test("cube_end", e0);
  endtask

  task automatic test_quiet();
    int e0;
    e0 = errors;
    quiet_err = 0;
    // equality compare with one nonzero word
    step();
    dma_wr_req_rdy     = 1'b0;
    reg2dp_ew_alu_algo = 2'd3;
    op_load            = 1'b1;
    step();
    op_load     = 1'b0;
    quiet_check = 1;
    for (int k = 0; k < 4; k++) begin
      lane_q[k].push_back((k == 2) ? ({$urandom, $urandom} | 64'h1) : 64'h0);
    end
    send_cmd(29'h0000_0100, 13'd3, 1'b0);
    wait_drain();
    check_val("dp2reg_status_unequal", dp2reg_status_unequal, 1);
    // routed to pooling with all zero data
    step();
    reg2dp_ew_alu_algo = 2'd0;
    reg2dp_output_dst  = 1'b1;
    op_load            = 1'b1;
    step();
    op_load = 1'b0;
    for (int k = 0; k < 8; k++) lane_q[k % NUM_LANES].push_back(64'h0);
    send_cmd(29'h0000_0200, 13'd7, 1'b0);
    wait_drain();
    check_val("dp2reg_status_unequal", dp2reg_status_unequal, 0);
    check_true(quiet_err == 0, "request valid raised in quiet mode");
    step();
    reg2dp_output_dst = 1'b0;
    dma_wr_req_rdy    = 1'b1;
    quiet_check       = 0;
    report_test("quiet_mode", e0);
  endtask

  // ============================================================
  // main sequence
  // ============================================================

  initial begin
    void'($urandom(32'h402f));
    autosa_core_rstn     = 1'b0;
    op_load              = 1'b0;
    cmd2dat_dma_pvld     = 1'b0;
    cmd2dat_dma_pd       = '0;
    dma_wr_req_rdy       = 1'b1;
    dfifo_rd_pvld        = '0;
    reg2dp_output_dst    = 1'b0;
    reg2dp_ew_alu_algo   = 2'd0;
    reg2dp_ew_alu_bypass = 1'b0;
    reg2dp_ew_bypass     = 1'b0;
    reg2dp_interrupt_ptr = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) dfifo_rd_pd[i] = '0;
    repeat (10) @(posedge autosa_core_clk);
    #2;
    autosa_core_rstn = 1'b1;
    test_reset();
    test_single();
    test_backpressure();
    test_cube_end();
    test_quiet();
    $display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* hdl/sdp_wdma_dat_out.sv */
// write-DMA data-out top, turns held commands and lane FIFO data into DMA write requests
`timescale 1ns/10ps

module sdp_wdma_dat_out #(
  parameter int NUM_LANES = sdp_wdma_pkg::NUM_LANES,
  parameter int LANE_W    = sdp_wdma_pkg::LANE_W,
  parameter int SIZE_W    = sdp_wdma_pkg::SIZE_W
) (
  input  logic                                   autosa_core_clk,
  input  logic                                   autosa_core_rstn,
  input  logic                                   op_load,
  // command input
  input  logic                                   cmd2dat_dma_pvld,
  input  logic [sdp_wdma_pkg::ADDR_W+SIZE_W+1:0] cmd2dat_dma_pd,
  output logic                                   cmd2dat_dma_prdy,
  // DMA write request
  output logic                                   dma_wr_req_vld,
  output logic [sdp_wdma_pkg::REQ_W-1:0]         dma_wr_req_pd,
  input  logic                                   dma_wr_req_rdy,
  // lane FIFOs
  input  logic [NUM_LANES-1:0]                   dfifo_rd_pvld,
  input  logic [LANE_W-1:0]                      dfifo_rd_pd [NUM_LANES],
  output logic [NUM_LANES-1:0]                   dfifo_rd_prdy,
  // config
  input  logic                                   reg2dp_output_dst,
  input  logic [1:0]                             reg2dp_ew_alu_algo,
  input  logic                                   reg2dp_ew_alu_bypass,
  input  logic                                   reg2dp_ew_bypass,
  input  logic                                   reg2dp_interrupt_ptr,
  // status and interrupt
  output logic                                   dp2reg_done,
  output logic                                   dp2reg_status_unequal,
  output logic                                   intr_req_ptr,
  output logic                                   intr_req_pvld
);

  import sdp_wdma_pkg::*;

  // holder to sequencer
  logic                         cmd_vld;
  logic [ADDR_W-1:0]            cmd_addr;
  logic [SIZE_W-1:0]            cmd_size;
  logic                         cmd_cube_end;
  logic                         cmd_release;
  // sequencer to lane mux
  logic [$clog2(NUM_LANES)-1:0] beat_idx;
  logic                         dat_rdy;
  logic                         dat_vld;
  logic [LANE_W-1:0]            dat_lane_pd;
  logic                         layer_end_pulse;

  sdp_wdma_cmd_hold #(.SIZE_W(SIZE_W)) u_cmd_hold (
    .autosa_core_clk(autosa_core_clk), .autosa_core_rstn(autosa_core_rstn),
    .cmd2dat_dma_pvld(cmd2dat_dma_pvld), .cmd2dat_dma_pd(cmd2dat_dma_pd),
    .cmd2dat_dma_prdy(cmd2dat_dma_prdy), .cmd_release(cmd_release),
    .cmd_vld(cmd_vld), .cmd_addr(cmd_addr), .cmd_size(cmd_size),
    .cmd_cube_end(cmd_cube_end)
  );

  sdp_wdma_lane_mux #(.NUM_LANES(NUM_LANES), .LANE_W(LANE_W)) u_lane_mux (
    .beat_idx(beat_idx), .dat_rdy(dat_rdy),
    .dfifo_rd_pvld(dfifo_rd_pvld), .dfifo_rd_pd(dfifo_rd_pd),
    .dfifo_rd_prdy(dfifo_rd_prdy), .dat_vld(dat_vld), .dat_lane_pd(dat_lane_pd)
  );

  sdp_wdma_beat_seq #(.SIZE_W(SIZE_W), .NUM_LANES(NUM_LANES), .LANE_W(LANE_W)) u_beat_seq (
    .autosa_core_clk(autosa_core_clk), .autosa_core_rstn(autosa_core_rstn),
    .cmd_vld(cmd_vld), .cmd_addr(cmd_addr), .cmd_size(cmd_size),
    .cmd_cube_end(cmd_cube_end), .cmd_release(cmd_release),
    .beat_idx(beat_idx), .dat_rdy(dat_rdy), .dat_vld(dat_vld), .dat_lane_pd(dat_lane_pd),
    .reg2dp_ew_bypass(reg2dp_ew_bypass), .reg2dp_ew_alu_bypass(reg2dp_ew_alu_bypass),
    .reg2dp_ew_alu_algo(reg2dp_ew_alu_algo), .reg2dp_output_dst(reg2dp_output_dst),
    .dma_wr_req_rdy(dma_wr_req_rdy), .dma_wr_req_vld(dma_wr_req_vld),
    .dma_wr_req_pd(dma_wr_req_pd), .layer_end_pulse(layer_end_pulse)
  );

  sdp_wdma_eq_status #(.NUM_LANES(NUM_LANES), .LANE_W(LANE_W)) u_eq_status (
    .autosa_core_clk(autosa_core_clk), .autosa_core_rstn(autosa_core_rstn),
    .op_load(op_load), .dfifo_rd_pvld(dfifo_rd_pvld), .dfifo_rd_prdy(dfifo_rd_prdy),
    .dfifo_rd_pd(dfifo_rd_pd), .layer_end_pulse(layer_end_pulse),
    .reg2dp_interrupt_ptr(reg2dp_interrupt_ptr),
    .dp2reg_status_unequal(dp2reg_status_unequal), .dp2reg_done(dp2reg_done),
    .intr_req_pvld(intr_req_pvld), .intr_req_ptr(intr_req_ptr)
  );

endmodule

/* hdl/sdp_wdma_eq_status.sv */
// status block, sticky inequality flag per lane, layer done and interrupt request
`timescale 1ns/10ps

module sdp_wdma_eq_status #(
  parameter int NUM_LANES = sdp_wdma_pkg::NUM_LANES,
  parameter int LANE_W    = sdp_wdma_pkg::LANE_W
) (
  input  logic                 autosa_core_clk,
  input  logic                 autosa_core_rstn,
  input  logic                 op_load,
  // lane reads as seen on the FIFO ports
  input  logic [NUM_LANES-1:0] dfifo_rd_pvld,
  input  logic [NUM_LANES-1:0] dfifo_rd_prdy,
  input  logic [LANE_W-1:0]    dfifo_rd_pd [NUM_LANES],
  // from the sequencer
  input  logic                 layer_end_pulse,
  input  logic                 reg2dp_interrupt_ptr,
  // register and interrupt side
  output logic                 dp2reg_status_unequal,
  output logic                 dp2reg_done,
  output logic                 intr_req_pvld,
  output logic                 intr_req_ptr
);

  logic [NUM_LANES-1:0] lane_unequal;

  // ============================================================
  // inequality flags
  // ============================================================

  // any nonzero word read means the compare failed
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      lane_unequal <= '0;
    end else if (op_load) begin
      lane_unequal <= '0;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (dfifo_rd_pvld[i] && dfifo_rd_prdy[i]) begin
          lane_unequal[i] <= lane_unequal[i] | (|dfifo_rd_pd[i]);
        end
      end
    end
  end

  assign dp2reg_status_unequal = |lane_unequal;

  // ============================================================
  // done and interrupt
  // ============================================================

  // done one cycle after the last beat
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      dp2reg_done <= 1'b0;
    end else begin
      dp2reg_done <= layer_end_pulse;
    end
  end

  // interrupt rides with the last beat itself
  assign intr_req_pvld = layer_end_pulse;
  assign intr_req_ptr  = reg2dp_interrupt_ptr;

endmodule

/* hdl/sdp_wdma_beat_seq.sv */
// beat sequencer, sends one DMA command packet then one data packet per beat of the held command
`timescale 1ns/10ps

module sdp_wdma_beat_seq #(
  parameter int SIZE_W    = sdp_wdma_pkg::SIZE_W,
  parameter int NUM_LANES = sdp_wdma_pkg::NUM_LANES,
  parameter int LANE_W    = sdp_wdma_pkg::LANE_W
) (
  input  logic                             autosa_core_clk,
  input  logic                             autosa_core_rstn,
  // held command
  input  logic                             cmd_vld,
  input  logic [sdp_wdma_pkg::ADDR_W-1:0]  cmd_addr,
  input  logic [SIZE_W-1:0]                cmd_size,
  input  logic                             cmd_cube_end,
  output logic                             cmd_release,
  // lane mux side
  output logic [$clog2(NUM_LANES)-1:0]     beat_idx,
  output logic                             dat_rdy,
  input  logic                             dat_vld,
  input  logic [LANE_W-1:0]                dat_lane_pd,
  // config
  input  logic                             reg2dp_ew_bypass,
  input  logic                             reg2dp_ew_alu_bypass,
  input  logic [1:0]                       reg2dp_ew_alu_algo,
  input  logic                             reg2dp_output_dst,
  // DMA write request
  input  logic                             dma_wr_req_rdy,
  output logic                             dma_wr_req_vld,
  output logic [sdp_wdma_pkg::REQ_W-1:0]   dma_wr_req_pd,
  // last beat of a cube end command
  output logic                             layer_end_pulse
);

  import sdp_wdma_pkg::*;

  logic              dat_phase;
  logic [SIZE_W-1:0] beat_count;
  logic              is_last_beat;
  logic              mode_eql;
  logic              mode_pdp;
  logic              mode_quiet;
  logic              dma_wr_rdy;
  logic              cmd_accept;
  logic              dat_accept;
  logic [REQ_W-1:0]  cmd_pkt;
  logic [REQ_W-1:0]  dat_pkt;

  // ============================================================
  // quiet mode decode
  // ============================================================

  // equality compare, result only goes to the status flag
  assign mode_eql   = !reg2dp_ew_bypass && !reg2dp_ew_alu_bypass &&
                      (reg2dp_ew_alu_algo == ALU_ALGO_EQL);
  // output routed to pooling
  assign mode_pdp   = reg2dp_output_dst;
  assign mode_quiet = mode_eql || mode_pdp;

  // quiet mode never stalls, lanes drain freely
  assign dma_wr_rdy = mode_quiet || dma_wr_req_rdy;

  // ============================================================
  // phase and beat count
  // ============================================================

  assign cmd_accept   = !dat_phase && cmd_vld && dma_wr_rdy;
  assign dat_rdy      = dat_phase && dma_wr_rdy;
  assign dat_accept   = dat_vld && dat_rdy;
  assign is_last_beat = (beat_count == cmd_size);

  assign cmd_release     = dat_accept && is_last_beat;
  assign layer_end_pulse = cmd_release && cmd_cube_end;

  // lane = beat modulo lane count
  assign beat_idx = beat_count[$clog2(NUM_LANES)-1:0];

  // command phase after reset
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      dat_phase <= 1'b0;
    end else if (cmd_accept) begin
      dat_phase <= 1'b1;
    end else if (cmd_release) begin
      dat_phase <= 1'b0;
    end
  end

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      beat_count <= '0;
    end else if (dat_accept) begin
      beat_count <= is_last_beat ? '0 : beat_count + 1'b1;
    end
  end

  // ============================================================
  // request packets
  // ============================================================

  always_comb begin
    cmd_pkt = '0;
    // 8-byte units to byte address
    cmd_pkt[CMD_ADDR_LSB-1:0]     = {cmd_addr, 3'b000};
    cmd_pkt[CMD_ADDR_LSB +: SIZE_W] = cmd_size;
    cmd_pkt[CMD_ACK_BIT]          = cmd_cube_end;
    cmd_pkt[REQ_TYPE_BIT]         = 1'b0;
  end

  always_comb begin
    dat_pkt = '0;
    dat_pkt[LANE_W-1:0]   = dat_lane_pd;
    // single lane per beat, mask always set
    dat_pkt[DAT_MASK_BIT] = 1'b1;
    dat_pkt[REQ_TYPE_BIT] = 1'b1;
  end

  assign dma_wr_req_pd  = dat_phase ? dat_pkt : cmd_pkt;
  assign dma_wr_req_vld = ((!dat_phase && cmd_vld) || (dat_phase && dat_vld)) && !mode_quiet;

endmodule

/* hdl/sdp_wdma_lane_mux.sv */
// lane selector, picks the lane FIFO for the current beat and gates its read strobe
`timescale 1ns/10ps

module sdp_wdma_lane_mux #(
  parameter int NUM_LANES = sdp_wdma_pkg::NUM_LANES,
  parameter int LANE_W    = sdp_wdma_pkg::LANE_W
) (
  // beat position and sequencer ready
  input  logic [$clog2(NUM_LANES)-1:0] beat_idx,
  input  logic                         dat_rdy,
  // lane FIFO read side
  input  logic [NUM_LANES-1:0]         dfifo_rd_pvld,
  input  logic [LANE_W-1:0]            dfifo_rd_pd [NUM_LANES],
  output logic [NUM_LANES-1:0]         dfifo_rd_prdy,
  // selected lane toward the sequencer
  output logic                         dat_vld,
  output logic [LANE_W-1:0]            dat_lane_pd
);

  logic [NUM_LANES-1:0] lane_en;

  // ============================================================
  // lane select
  // ============================================================

  // one-hot from beat index
  always_comb begin
    lane_en = '0;
    lane_en[beat_idx] = 1'b1;
  end

  // only the selected lane may see a ready
  assign dfifo_rd_prdy = lane_en & {NUM_LANES{dat_rdy}};

  // valid of the selected lane only
  assign dat_vld = |(lane_en & dfifo_rd_pvld);

  // ============================================================
  // data mux
  // ============================================================

  // and-or mux over the lanes
  always_comb begin
    dat_lane_pd = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_en[i]) begin
        dat_lane_pd = dfifo_rd_pd[i];
      end
    end
  end

endmodule

/* hdl/sdp_wdma_cmd_hold.sv */
// one-deep command holder, keeps the current DMA command until its last data beat is taken
`timescale 1ns/10ps

module sdp_wdma_cmd_hold #(
  parameter int SIZE_W = sdp_wdma_pkg::SIZE_W
) (
  input  logic                                   autosa_core_clk,
  input  logic                                   autosa_core_rstn,
  // command from the address generator
  input  logic                                   cmd2dat_dma_pvld,
  input  logic [sdp_wdma_pkg::ADDR_W+SIZE_W+1:0] cmd2dat_dma_pd,
  output logic                                   cmd2dat_dma_prdy,
  // held command toward the sequencer
  input  logic                                   cmd_release,
  output logic                                   cmd_vld,
  output logic [sdp_wdma_pkg::ADDR_W-1:0]        cmd_addr,
  output logic [SIZE_W-1:0]                      cmd_size,
  output logic                                   cmd_cube_end
);

  import sdp_wdma_pkg::*;

  logic [ADDR_W-1:0] in_addr;
  logic [SIZE_W-1:0] in_size;
  logic              in_cube_end;
  logic              cmd_take;

  // unpack, odd bit at ADDR_W+SIZE_W is not used
  assign in_addr     = cmd2dat_dma_pd[ADDR_W-1:0];
  assign in_size     = cmd2dat_dma_pd[ADDR_W +: SIZE_W];
  assign in_cube_end = cmd2dat_dma_pd[ADDR_W+SIZE_W+1];

  // empty, or the held one leaves this cycle
  assign cmd2dat_dma_prdy = !cmd_vld || cmd_release;
  assign cmd_take         = cmd2dat_dma_pvld && cmd2dat_dma_prdy;

  // holder valid
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      cmd_vld <= 1'b0;
    end else if (cmd2dat_dma_prdy) begin
      cmd_vld <= cmd2dat_dma_pvld;
    end
  end

  // command fields
  always_ff @(posedge autosa_core_clk) begin
    if (cmd_take) begin
      cmd_addr     <= in_addr;
      cmd_size     <= in_size;
      cmd_cube_end <= in_cube_end;
    end
  end

endmodule

/* hdl/sdp_wdma_pkg.sv */
// shared widths, request packet layout and mode codes, imported by every write-DMA data-out block
package sdp_wdma_pkg;

  // ============================================================
  // command fields
  // ============================================================

  // address in 8-byte units
  localparam int ADDR_W = 29;
  // beats minus one
  localparam int SIZE_W = 13;

  // ============================================================
  // lane FIFOs
  // ============================================================

  localparam int LANE_W     = 64;
  // must stay a power of two, lane = beat index modulo lane count
  localparam int NUM_LANES  = 4;
  localparam int LANE_IDX_W = $clog2(NUM_LANES);

  // ============================================================
  // DMA write request packet
  // ============================================================

  localparam int REQ_W        = 66;
  // 0 = command packet, 1 = data packet
  localparam int REQ_TYPE_BIT = 65;
  // command: byte address below, size field starts here
  localparam int CMD_ADDR_LSB = 32;
  // command: cube end asks the DMA for a write ack
  localparam int CMD_ACK_BIT  = 45;
  // data: one mask bit, one lane per beat
  localparam int DAT_MASK_BIT = 64;

  // ============================================================
  // config decode
  // ============================================================

  // element-wise ALU equality compare
  localparam logic [1:0] ALU_ALGO_EQL = 2'd3;

endpackage
